// ==== hdl/soc_map_pkg.sv ====
package soc_map_pkg;

    // ====================================================================
    // Memory regions
    // ====================================================================

    // Boot code, read only from the data bus
    localparam logic [31:0] rom_base = 32'h0000_0000;
    // 1 KiB, 256 words
    localparam logic [31:0] rom_size = 32'h0000_0400;

    // Writable RAM directly above the boot region
    localparam logic [31:0] ram_base = 32'h0000_0400;
    // 2 KiB, 512 words
    localparam logic [31:0] ram_size = 32'h0000_0800;

    // ====================================================================
    // Device registers
    // ====================================================================

    // Keyboard status, a read clears key valid
    localparam logic [31:0] key_addr = 32'h0000_3000;

    // Console data byte, write only
    localparam logic [31:0] con_addr = 32'h0000_3004;

    // Console status, tx busy flag
    localparam logic [31:0] con_stat_addr = 32'h0000_3008;

endpackage

// ==== hdl/soc_bus_pkg.sv ====
package soc_bus_pkg;

    // Master request, 66 bits
    // Read enable held until read done, write strobe one cycle
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        we;
        logic        re;
    } bus_req_t;

    // Device status word
    // Same layout for keyboard and console status reads
    typedef struct packed {
        logic        key_valid;
        logic        key_pressed;
        logic        tx_busy;
        logic [20:0] zero;
        logic [7:0]  ascii;
    } key_status_t;

    // Read data, raw memory word or status view
    typedef union packed {
        logic [31:0] raw;
        key_status_t key;
    } bus_word_u;

    // Slave response, 33 bits
    // Data valid in the single cycle that done is high
    typedef struct packed {
        bus_word_u data;
        logic      done;
    } bus_rsp_t;

    // One decoded keyboard code, 18 bits
    typedef struct packed {
        logic [7:0] scan;
        logic [7:0] ascii;
        logic       pressed;
        logic       released;
    } key_event_t;

endpackage

// ==== hdl/bus_controller.sv ====
`timescale 1ns/1ps

module bus_controller (
    input  logic                    clk,
    input  logic                    KEY0,
    input  soc_bus_pkg::bus_req_t   bus_req,
    output soc_bus_pkg::bus_rsp_t   bus_rsp,
    output logic [9:0]              mem_addr,
    output logic [31:0]             mem_wdata,
    output logic                    mem_we,
    input  logic [31:0]             mem_rdata,
    input  soc_bus_pkg::key_event_t key_ev,
    output logic [7:0]              con_data,
    output logic                    con_load,
    input  logic                    con_busy
);

    // Read FSM states
    localparam logic [1:0] RD_IDLE = 2'd0;
    localparam logic [1:0] RD_MEM  = 2'd1;
    localparam logic [1:0] RD_HOLD = 2'd2;

    logic                   rom_sel;
    logic                   ram_sel;
    logic                   key_sel;
    logic                   stat_sel;
    logic                   con_sel;
    logic [1:0]             rd_state;
    logic                   rd_start;
    logic                   rd_done;
    soc_bus_pkg::bus_word_u rd_data;
    soc_bus_pkg::bus_word_u status;
    logic                   key_valid;
    logic                   key_down;
    logic [7:0]             key_ascii;
    logic                   con_wr;
    logic                   con_wr_q;
    logic                   con_start;

    // ====================================================================
    // Address decode
    // ====================================================================
    // Offset compare, wraps for addresses below the base
    assign rom_sel  = (bus_req.addr - soc_map_pkg::rom_base) < soc_map_pkg::rom_size;
    assign ram_sel  = (bus_req.addr - soc_map_pkg::ram_base) < soc_map_pkg::ram_size;
    assign key_sel  = bus_req.addr == soc_map_pkg::key_addr;
    assign stat_sel = bus_req.addr == soc_map_pkg::con_stat_addr;
    assign con_sel  = bus_req.addr == soc_map_pkg::con_addr;

    // Memory data port, absolute word index
    assign mem_addr  = bus_req.addr[11:2];
    assign mem_wdata = bus_req.wdata;
    // Boot region and unmapped writes dropped here
    assign mem_we    = bus_req.we && ram_sel;

    // Status word as seen through the union
    always_comb begin
        status.raw             = '0;
        status.key.key_valid   = key_valid;
        status.key.key_pressed = key_down;
        status.key.tx_busy     = con_busy;
        status.key.ascii       = key_ascii;
    end

    // ====================================================================
    // Read sequencing
    // ====================================================================
    // New read seen in idle
    assign rd_start = (rd_state == RD_IDLE) && bus_req.re;

    always_ff @(posedge clk or negedge KEY0) begin
        if (!KEY0) begin
            rd_state <= RD_IDLE;
            rd_done  <= 1'b0;
        end else begin
            rd_done <= 1'b0;
            case (rd_state)
                RD_IDLE: begin
                    if (bus_req.re && (rom_sel || ram_sel)) begin
                        rd_state <= RD_MEM;
                    end else if (bus_req.re) begin
                        // Devices and unmapped, one cycle
                        rd_done  <= 1'b1;
                        rd_state <= RD_HOLD;
                    end
                end
                RD_MEM: begin
                    // Memory output registered last edge
                    rd_done  <= 1'b1;
                    rd_state <= RD_HOLD;
                end
                RD_HOLD: begin
                    // Wait for the master to drop re
                    if (!bus_req.re) begin
                        rd_state <= RD_IDLE;
                    end
                end
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_state == RD_MEM) begin
            rd_data.raw <= mem_rdata;
        end else if (rd_start && (key_sel || stat_sel)) begin
            rd_data <= status;
        end else if (rd_start) begin
            rd_data.raw <= '0;
        end
    end

    assign bus_rsp.data = rd_data;
    assign bus_rsp.done = rd_done;

    // ====================================================================
    // Keyboard status register
    // ====================================================================
    always_ff @(posedge clk or negedge KEY0) begin
        if (!KEY0) begin
            key_valid <= 1'b0;
            key_down  <= 1'b0;
            key_ascii <= 8'h00;
        end else begin
            // New make code wins over a clearing read
            if (key_ev.pressed) begin
                key_valid <= 1'b1;
                key_down  <= 1'b1;
                key_ascii <= key_ev.ascii;
            end else if (rd_start && key_sel) begin
                key_valid <= 1'b0;
            end
            if (key_ev.released) begin
                key_down <= 1'b0;
            end
        end
    end

    // ====================================================================
    // Console write trigger
    // ====================================================================
    assign con_wr    = bus_req.we && con_sel;
    // Rising edge only, busy or pending load drops it
    assign con_start = con_wr && !con_wr_q && !con_busy && !con_load;

    always_ff @(posedge clk or negedge KEY0) begin
        if (!KEY0) begin
            con_wr_q <= 1'b0;
            con_load <= 1'b0;
        end else begin
            con_wr_q <= con_wr;
            con_load <= con_start;
        end
    end

    always_ff @(posedge clk) begin
        if (con_start) begin
            con_data <= bus_req.wdata[7:0];
        end
    end

    // Master never mixes read and write
    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!KEY0)
        !(bus_req.re && bus_req.we));

    // Master still holds re when read done arrives
    a_done_held: assert property (@(posedge clk) disable iff (!KEY0)
        rd_done |-> bus_req.re);

endmodule

// ==== hdl/boot_ram.sv ====
`timescale 1ns/1ps

module boot_ram #(
    parameter int MEM_WORDS = 768
) (
    input  logic        clk,
    input  logic [31:0] fetch_addr,
    output logic [31:0] instr,
    input  logic [9:0]  addr,
    input  logic [31:0] wdata,
    input  logic        we,
    output logic [31:0] rdata
);

    logic [31:0] mem [0:MEM_WORDS-1];
    logic [9:0]  fetch_idx;
    logic [31:0] fetch_word;

    // Zero-filled image, boot region reads as zero
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // ====================================================================
    // Fetch port
    // ====================================================================
    assign fetch_idx  = fetch_addr[11:2];
    // Out of range fetch gives zero
    assign fetch_word = (fetch_idx < MEM_WORDS) ? mem[fetch_idx] : '0;

    // Byte order reversed for the core
    always_ff @(posedge clk) begin
        instr <= {<<8{fetch_word}};
    end

    // ====================================================================
    // Data port
    // ====================================================================
    // Read before write on the same address
    always_ff @(posedge clk) begin
        if (we && (addr < MEM_WORDS)) begin
            mem[addr] <= wdata;
        end
        rdata <= (addr < MEM_WORDS) ? mem[addr] : '0;
    end

endmodule

// ==== hdl/ps2_receiver.sv ====
`timescale 1ns/1ps

module ps2_receiver (
    input  logic                    clk,
    input  logic                    KEY0,
    input  logic                    ps2_clk,
    input  logic                    ps2_dat,
    output soc_bus_pkg::key_event_t key_ev
);

    logic [2:0]  clk_sync;
    logic [1:0]  dat_sync;
    logic        clk_fall;
    logic [10:0] shreg;
    logic [10:0] frame;
    logic [3:0]  bit_cnt;
    logic        frame_ok;
    logic        brk;

    // Set 2 scan codes, lower case letters and digits
    function automatic logic [7:0] scan_to_ascii(input logic [7:0] code);
        case (code)
            8'h1C: scan_to_ascii = "a";
            8'h32: scan_to_ascii = "b";
            8'h21: scan_to_ascii = "c";
            8'h23: scan_to_ascii = "d";
            8'h24: scan_to_ascii = "e";
            8'h2B: scan_to_ascii = "f";
            8'h34: scan_to_ascii = "g";
            8'h33: scan_to_ascii = "h";
            8'h43: scan_to_ascii = "i";
            8'h3B: scan_to_ascii = "j";
            8'h42: scan_to_ascii = "k";
            8'h4B: scan_to_ascii = "l";
            8'h3A: scan_to_ascii = "m";
            8'h31: scan_to_ascii = "n";
            8'h44: scan_to_ascii = "o";
            8'h4D: scan_to_ascii = "p";
            8'h15: scan_to_ascii = "q";
            8'h2D: scan_to_ascii = "r";
            8'h1B: scan_to_ascii = "s";
            8'h2C: scan_to_ascii = "t";
            8'h3C: scan_to_ascii = "u";
            8'h2A: scan_to_ascii = "v";
            8'h1D: scan_to_ascii = "w";
            8'h22: scan_to_ascii = "x";
            8'h35: scan_to_ascii = "y";
            8'h1A: scan_to_ascii = "z";
            8'h45: scan_to_ascii = "0";
            8'h16: scan_to_ascii = "1";
            8'h1E: scan_to_ascii = "2";
            8'h26: scan_to_ascii = "3";
            8'h25: scan_to_ascii = "4";
            8'h2E: scan_to_ascii = "5";
            8'h36: scan_to_ascii = "6";
            8'h3D: scan_to_ascii = "7";
            8'h3E: scan_to_ascii = "8";
            8'h46: scan_to_ascii = "9";
            default: scan_to_ascii = 8'h00;
        endcase
    endfunction

    // ====================================================================
    // Line sync and frame shifter
    // ====================================================================
    always_ff @(posedge clk or negedge KEY0) begin
        if (!KEY0) begin
            // Both lines idle high
            clk_sync <= 3'b111;
            dat_sync <= 2'b11;
        end else begin
            clk_sync <= {clk_sync[1:0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
        end
    end

    // Device changes data on rising, sample on falling
    assign clk_fall = clk_sync[2] && !clk_sync[1];
    // LSB first, so new bit enters at the top
    assign frame    = {dat_sync[1], shreg[10:1]};
    // Start low, stop high, odd parity over data and parity
    assign frame_ok = !frame[0] && frame[10] && (^frame[9:1]);

    always_ff @(posedge clk or negedge KEY0) begin
        if (!KEY0) begin
            shreg   <= '0;
            bit_cnt <= 4'd0;
        end else if (clk_fall) begin
            shreg   <= frame;
            bit_cnt <= (bit_cnt == 4'd10) ? 4'd0 : bit_cnt + 4'd1;
        end
    end

    // ====================================================================
    // Make and break tracking
    // ====================================================================
    always_ff @(posedge clk or negedge KEY0) begin
        if (!KEY0) begin
            key_ev <= '0;
            brk    <= 1'b0;
        end else begin
            key_ev.pressed  <= 1'b0;
            key_ev.released <= 1'b0;
            // Eleventh bit closes the frame
            if (clk_fall && (bit_cnt == 4'd10) && frame_ok) begin
                if (frame[8:1] == 8'hF0) begin
                    brk <= 1'b1;
                end else begin
                    key_ev.scan     <= frame[8:1];
                    key_ev.ascii    <= scan_to_ascii(frame[8:1]);
                    key_ev.pressed  <= !brk;
                    key_ev.released <= brk;
                    brk             <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== hdl/console_tx.sv ====
`timescale 1ns/1ps

module console_tx #(
    parameter int CLKS_PER_BIT = 434
) (
    input  logic       clk,
    input  logic       KEY0,
    input  logic [7:0] data,
    input  logic       load,
    output logic       busy,
    output logic       txd
);

    localparam int               DIV_W    = $clog2(CLKS_PER_BIT + 1);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(CLKS_PER_BIT - 1);

    logic [DIV_W-1:0] div_cnt;
    logic [3:0]       bit_cnt;
    // Data bits then stop bit, next bit at the bottom
    logic [8:0]       shreg;

    // ====================================================================
    // 8N1 shifter
    // ====================================================================
    always_ff @(posedge clk or negedge KEY0) begin
        if (!KEY0) begin
            busy    <= 1'b0;
            txd     <= 1'b1;
            div_cnt <= '0;
            bit_cnt <= 4'd0;
            shreg   <= '1;
        end else if (load && !busy) begin
            // Start bit from the next cycle
            busy    <= 1'b1;
            txd     <= 1'b0;
            shreg   <= {1'b1, data};
            div_cnt <= '0;
            bit_cnt <= 4'd0;
        end else if (busy) begin
            if (div_cnt == DIV_LAST) begin
                div_cnt <= '0;
                if (bit_cnt == 4'd9) begin
                    // Stop bit done, line stays high
                    busy <= 1'b0;
                    txd  <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                    txd     <= shreg[0];
                    shreg   <= {1'b1, shreg[8:1]};
                end
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // Controller holds loads back while a frame runs
    a_load_idle: assert property (@(posedge clk) disable iff (!KEY0)
        load |-> !busy);

endmodule

// ==== hdl/irq_controller.sv ====
`timescale 1ns/1ps

module irq_controller (
    input  logic                    clk,
    input  logic                    KEY0,
    input  soc_bus_pkg::key_event_t key_ev,
    input  logic                    irq_ack,
    output logic [3:0]              irq_vector
);

    // Vector 1 is the keyboard
    // Held until acknowledged, ack wins a tie
    always_ff @(posedge clk or negedge KEY0) begin
        if (!KEY0) begin
            irq_vector <= 4'd0;
        end else if (irq_ack) begin
            irq_vector <= 4'd0;
        end else if (key_ev.pressed && (key_ev.ascii != 8'h00)) begin
            // Keys without a table entry raise nothing
            irq_vector <= 4'd1;
        end
    end

endmodule

// ==== hdl/soc_bus_top.sv ====
`timescale 1ns/1ps

module soc_bus_top #(
    parameter int MEM_WORDS    = 768,
    parameter int CLKS_PER_BIT = 434
) (
    input  logic                  CLOCK_50,
    input  logic                  KEY0,
    input  soc_bus_pkg::bus_req_t bus_req,
    output soc_bus_pkg::bus_rsp_t bus_rsp,
    input  logic [31:0]           fetch_addr,
    output logic [31:0]           instr,
    input  logic                  ps2_clk,
    input  logic                  ps2_dat,
    output logic                  con_txd,
    input  logic                  irq_ack,
    output logic [3:0]            irq_vector
);

    // Memory data port
    logic [9:0]              mem_addr;
    logic [31:0]             mem_wdata;
    logic                    mem_we;
    logic [31:0]             mem_rdata;
    // Keyboard events to status and interrupt
    soc_bus_pkg::key_event_t key_ev;
    // Console
    logic [7:0]              con_data;
    logic                    con_load;
    logic                    con_busy;

    // ====================================================================
    // Bus side
    // ====================================================================
    bus_controller bus_controller_i (
        .clk       (CLOCK_50),
        .KEY0      (KEY0),
        .bus_req   (bus_req),
        .bus_rsp   (bus_rsp),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we),
        .mem_rdata (mem_rdata),
        .key_ev    (key_ev),
        .con_data  (con_data),
        .con_load  (con_load),
        .con_busy  (con_busy)
    );

    boot_ram #(
        .MEM_WORDS (MEM_WORDS)
    ) boot_ram_i (
        .clk        (CLOCK_50),
        .fetch_addr (fetch_addr),
        .instr      (instr),
        .addr       (mem_addr),
        .wdata      (mem_wdata),
        .we         (mem_we),
        .rdata      (mem_rdata)
    );

    // ====================================================================
    // Devices
    // ====================================================================
    ps2_receiver ps2_receiver_i (
        .clk     (CLOCK_50),
        .KEY0    (KEY0),
        .ps2_clk (ps2_clk),
        .ps2_dat (ps2_dat),
        .key_ev  (key_ev)
    );

    console_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) console_tx_i (
        .clk  (CLOCK_50),
        .KEY0 (KEY0),
        .data (con_data),
        .load (con_load),
        .busy (con_busy),
        .txd  (con_txd)
    );

    irq_controller irq_controller_i (
        .clk        (CLOCK_50),
        .KEY0       (KEY0),
        .key_ev     (key_ev),
        .irq_ack    (irq_ack),
        .irq_vector (irq_vector)
    );

endmodule

// ==== testbench/soc_bus_tb.sv ====
`timescale 1ns/1ps

module soc_bus_tb;

    localparam int CLKS_PER_BIT = 8;
    // PS/2 half period in system cycles
    localparam int PS2_HALF     = 20;
    localparam int DONE_LIMIT   = 50;
    localparam int POLL_LIMIT   = 20;

    logic                  CLOCK_50;
    logic                  KEY0;
    soc_bus_pkg::bus_req_t bus_req;
    soc_bus_pkg::bus_rsp_t bus_rsp;
    logic [31:0]           fetch_addr;
    logic [31:0]           instr;
    logic                  ps2_clk;
    logic                  ps2_dat;
    logic                  con_txd;
    logic                  irq_ack;
    logic [3:0]            irq_vector;

    int                     errors;
    int                     checks;
    integer                 seed;
    integer                 fd;
    integer                 n;
    logic [7:0]             op;
    logic [31:0]            a;
    logic [31:0]            b;
    logic [31:0]            rd;
    int                     lat;
    string                  line;
    soc_bus_pkg::bus_word_u word;
    // Expected memory contents for random data lines
    logic [31:0]            model [0:767];

    soc_bus_top #(
        .MEM_WORDS    (768),
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) soc_bus_top_i (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .bus_req    (bus_req),
        .bus_rsp    (bus_rsp),
        .fetch_addr (fetch_addr),
        .instr      (instr),
        .ps2_clk    (ps2_clk),
        .ps2_dat    (ps2_dat),
        .con_txd    (con_txd),
        .irq_ack    (irq_ack),
        .irq_vector (irq_vector)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #50 CLOCK_50 = ~CLOCK_50;
    end

    // ====================================================================
    // Check and abort helpers
    // ====================================================================
    task check_equal(input logic [31:0] actual, input logic [31:0] expected, input string msg);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED time %0t: %s, got %h, expected %h",
                     $time, msg, actual, expected);
        end
    endtask

    task abort_run(input string msg);
        $display("ERROR: %s", msg);
        $display("Checks: %0d, errors: %0d", checks, errors + 1);
        $display("CHECKS FAILED");
        $finish;
    endtask

    // Little-endian fetch view of a word
    function automatic logic [31:0] reverse_bytes(input logic [31:0] d);
        reverse_bytes = {d[7:0], d[15:8], d[23:16], d[31:24]};
    endfunction

    // ROM and RAM complete in 2 cycles, all else in 1
    function automatic int read_latency(input logic [31:0] addr);
        if ((addr < soc_map_pkg::rom_base + soc_map_pkg::rom_size) ||
            ((addr >= soc_map_pkg::ram_base) &&
             (addr < soc_map_pkg::ram_base + soc_map_pkg::ram_size))) begin
            read_latency = 2;
        end else begin
            read_latency = 1;
        end
    endfunction

    task idle_cycles(input int cnt);
        repeat (cnt) @(posedge CLOCK_50);
    endtask

    // ====================================================================
    // Bus master
    // ====================================================================
    task bus_write(input logic [31:0] addr, input logic [31:0] data);
        @(posedge CLOCK_50);
        bus_req.addr  <= addr;
        bus_req.wdata <= data;
        bus_req.we    <= 1'b1;
        @(posedge CLOCK_50);
        bus_req.we    <= 1'b0;
        // Only RAM takes writes
        if ((addr >= soc_map_pkg::ram_base) &&
            (addr < soc_map_pkg::ram_base + soc_map_pkg::ram_size)) begin
            model[addr[11:2]] = data;
        end
    endtask

    // Latency counted in rising edges after re goes high
    task bus_read(input logic [31:0] addr, output logic [31:0] data, output int cycles);
        logic seen;
        seen   = 1'b0;
        cycles = 0;
        @(posedge CLOCK_50);
        bus_req.addr <= addr;
        bus_req.re   <= 1'b1;
        while (!seen) begin
            @(negedge CLOCK_50);
            if (bus_rsp.done) begin
                seen = 1'b1;
            end else begin
                cycles++;
                if (cycles > DONE_LIMIT) begin
                    abort_run($sformatf("Read of %h never got read done", addr));
                end
            end
        end
        data = bus_rsp.data.raw;
        @(posedge CLOCK_50);
        bus_req.re <= 1'b0;
        // Idle cycle before the next read
        @(posedge CLOCK_50);
    endtask

    task fetch_check(input logic [31:0] addr, input logic [31:0] expected);
        @(posedge CLOCK_50);
        fetch_addr <= addr;
        @(posedge CLOCK_50);
        @(negedge CLOCK_50);
        check_equal(instr, expected, $sformatf("fetch of %h", addr));
    endtask

    // ====================================================================
    // PS/2 device model
    // ====================================================================
    // Start, 8 data LSB first, odd parity, stop
    task send_frame(input logic [7:0] code);
        logic [10:0] bits;
        bits = {1'b1, ~^code, code, 1'b0};
        for (int i = 0; i < 11; i++) begin
            @(posedge CLOCK_50);
            ps2_dat <= bits[i];
            idle_cycles(PS2_HALF / 2);
            ps2_clk <= 1'b0;
            idle_cycles(PS2_HALF);
            ps2_clk <= 1'b1;
            idle_cycles(PS2_HALF / 2);
        end
        ps2_dat <= 1'b1;
    endtask

    // Make code, poll status until key valid
    task key_press(input logic [7:0] scan, input logic [7:0] ascii);
        int polls;
        polls = 0;
        word  = '0;
        send_frame(scan);
        while (!word.key.key_valid) begin
            bus_read(soc_map_pkg::key_addr, rd, lat);
            word.raw = rd;
            polls++;
            if (!word.key.key_valid && (polls > POLL_LIMIT)) begin
                abort_run($sformatf("Key %h was never reported valid", scan));
            end
        end
        check_equal({24'h0, word.key.ascii}, {24'h0, ascii}, "key ascii");
        check_equal({31'h0, word.key.key_pressed}, 32'd1, "key pressed flag");
    endtask

    // Break sequence, key valid must stay clear
    task key_release(input logic [7:0] scan);
        int polls;
        polls    = 0;
        word.raw = 32'hFFFF_FFFF;
        send_frame(8'hF0);
        send_frame(scan);
        while (word.key.key_pressed) begin
            bus_read(soc_map_pkg::key_addr, rd, lat);
            word.raw = rd;
            check_equal({31'h0, word.key.key_valid}, 32'd0, "key valid after break");
            polls++;
            if (word.key.key_pressed && (polls > POLL_LIMIT)) begin
                abort_run($sformatf("Release of key %h never seen", scan));
            end
        end
    endtask

    task ack_check(input logic [3:0] vec);
        @(posedge CLOCK_50);
        irq_ack <= 1'b1;
        // Still held in the ack cycle
        @(negedge CLOCK_50);
        check_equal({28'h0, irq_vector}, {28'h0, vec}, "irq vector before ack");
        @(posedge CLOCK_50);
        irq_ack <= 1'b0;
        @(negedge CLOCK_50);
        check_equal({28'h0, irq_vector}, 32'd0, "irq vector after ack");
    endtask

    // ====================================================================
    // Console capture
    // ====================================================================
    // Mid-bit sampling from the start bit edge
    task capture_frame(output logic [7:0] rx);
        int waited;
        waited = 0;
        @(negedge CLOCK_50);
        while (con_txd !== 1'b0) begin
            waited++;
            if (waited > 4 * CLKS_PER_BIT) begin
                abort_run("Console start bit never appeared");
            end
            @(negedge CLOCK_50);
        end
        repeat (CLKS_PER_BIT / 2) @(negedge CLOCK_50);
        check_equal({31'h0, con_txd}, 32'd0, "console start bit");
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge CLOCK_50);
            rx[i] = con_txd;
        end
        repeat (CLKS_PER_BIT) @(negedge CLOCK_50);
        check_equal({31'h0, con_txd}, 32'd1, "console stop bit");
    endtask

    task console_check(input logic [7:0] data);
        logic [7:0]  rx;
        logic [31:0] st;
        int          st_lat;
        int          lows;
        lows = 0;
        bus_write(soc_map_pkg::con_addr, {24'h0, data});
        fork
            capture_frame(rx);
            begin
                // Mid-frame status, then a write that must be dropped
                idle_cycles(3 * CLKS_PER_BIT);
                bus_read(soc_map_pkg::con_stat_addr, st, st_lat);
                word.raw = st;
                check_equal({31'h0, word.key.tx_busy}, 32'd1, "console busy in frame");
                check_equal(st_lat, 32'd1, "console status latency");
                bus_write(soc_map_pkg::con_addr, {24'h0, ~data});
            end
        join
        check_equal({24'h0, rx}, {24'h0, data}, "console byte");
        // No second frame
        repeat (12 * CLKS_PER_BIT) begin
            @(negedge CLOCK_50);
            if (con_txd !== 1'b1) begin
                lows++;
            end
        end
        check_equal(lows, 32'd0, "console idle after frame");
    endtask

    // ====================================================================
    // Main sequence
    // ====================================================================
    initial begin
        KEY0       = 1'b0;
        bus_req    = '0;
        fetch_addr = '0;
        ps2_clk    = 1'b1;
        ps2_dat    = 1'b1;
        irq_ack    = 1'b0;
        errors     = 0;
        checks     = 0;
        seed       = 46;
        for (int i = 0; i < 768; i++) begin
            model[i] = '0;
        end
        repeat (5) @(posedge CLOCK_50);
        KEY0 <= 1'b1;
        idle_cycles(2);

        fd = $fopen("testbench/soc_bus_stim.txt", "r");
        if (fd == 0) begin
            abort_run("Cannot open testbench/soc_bus_stim.txt");
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, " %c", op);
            if (n == 1) begin
                case (op)
                    "#": n = $fgets(line, fd);
                    "W": begin
                        n = $fscanf(fd, "%h %h", a, b);
                        bus_write(a, b);
                    end
                    "R": begin
                        n = $fscanf(fd, "%h %h", a, b);
                        bus_read(a, rd, lat);
                        check_equal(rd, b, $sformatf("read of %h", a));
                        check_equal(lat, read_latency(a), $sformatf("latency at %h", a));
                    end
                    "F": begin
                        n = $fscanf(fd, "%h %h", a, b);
                        fetch_check(a, b);
                    end
                    "X": begin
                        // Random word into RAM, read back, fetch swapped
                        n = $fscanf(fd, "%h", a);
                        bus_write(a, $random(seed));
                        bus_read(a, rd, lat);
                        check_equal(rd, model[a[11:2]], $sformatf("random read %h", a));
                        fetch_check(a, reverse_bytes(model[a[11:2]]));
                    end
                    "K": begin
                        n = $fscanf(fd, "%h %h", a, b);
                        key_press(a[7:0], b[7:0]);
                    end
                    "B": begin
                        n = $fscanf(fd, "%h", a);
                        key_release(a[7:0]);
                    end
                    "C": begin
                        n = $fscanf(fd, "%h", a);
                        console_check(a[7:0]);
                    end
                    "A": begin
                        n = $fscanf(fd, "%h", a);
                        ack_check(a[3:0]);
                    end
                    default: abort_run("Unknown opcode in stimulus file");
                endcase
            end
        end
        $fclose(fd);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== testbench/soc_bus_stim.txt ====
# Op and hex fields: W addr data, R addr expected, F addr expected instr, X addr
# K scan expected ascii, B scan (break), C console byte, A expected irq vector
W 00000400 11223344
R 00000400 11223344
F 00000400 44332211
W 00000404 a5b6c7d8
R 00000404 a5b6c7d8
F 00000404 d8c7b6a5
# Boot region is read only
W 00000010 deadbeef
R 00000010 00000000
F 00000010 00000000
X 00000408
X 00000bfc
X 00000700
# Unmapped space
R 00005000 00000000
W 00005000 12345678
R 00005000 00000000
# Console
R 00003008 00000000
C 5a
C c3
R 00003008 00000000
# Keyboard and interrupt
A 0
K 1c 61
R 00003000 40000061
A 1
B 1c
R 00003000 00000061
K 76 00
R 00003000 40000000
A 0
K 3e 38
A 1

// ==== src.f ====
hdl/soc_map_pkg.sv
hdl/soc_bus_pkg.sv
hdl/bus_controller.sv
hdl/boot_ram.sv
hdl/ps2_receiver.sv
hdl/console_tx.sv
hdl/irq_controller.sv
hdl/soc_bus_top.sv
testbench/soc_bus_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module soc_bus_tb -f src.f -o soc_bus_sim

out=$(./obj_dir/soc_bus_sim)
echo "$out"

if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
